// File: rtl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    typedef logic [31:0] addr_t;       // cpu byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_n_t;       // active-low byte enables
    typedef logic [19:0] sram_addr_t;  // word address from byte addr [21:2]
    typedef logic [7:0]  byte_t;

    // address map with two 4 MiB rams
    localparam addr_t BASE_RAM_BASE   = 32'h8000_0000;
    localparam addr_t EXT_RAM_BASE    = 32'h8040_0000;
    localparam addr_t RAM_REGION_MASK = 32'hFFC0_0000;
    localparam addr_t UART_DATA_ADDR  = 32'hBFD0_03F8;
    localparam addr_t UART_STAT_ADDR  = 32'hBFD0_03FC;

    // status register layout
    localparam int STAT_TX_READY_BIT = 0;  // transmitter idle
    localparam int STAT_RX_AVAIL_BIT = 1;  // byte waiting in buffer

    // serial timing
    localparam int CLK_FREQ_HZ  = 50_000_000;
    localparam int BAUD_RATE    = 115_200;
    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;  // 434

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

    // last count of a bit period, and of half a period
    localparam baud_cnt_t BIT_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t BIT_HALF = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

    // shared by receiver and transmitter
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  wire                 clk_i,
    input  wire                 locked_i,
    input  wire                 rxd_i,
    output soc_bus_pkg::byte_t  rx_data_o,
    output logic                rx_ready_o
);
    import soc_bus_pkg::*;

    logic [1:0]  rxd_sync_q;
    logic        rxd_s;
    uart_state_t state_q;
    baud_cnt_t   clk_cnt_q;
    logic [2:0]  bit_idx_q;
    logic        bit_end;
    logic        half_end;
    byte_t       shift_q;

    assign rxd_s    = rxd_sync_q[1];
    assign bit_end  = clk_cnt_q == BIT_LAST;
    assign half_end = clk_cnt_q == BIT_HALF;

    // two-flop synchronizer
    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            rxd_sync_q <= 2'b11;  // line idles high
        end else begin
            rxd_sync_q <= {rxd_sync_q[0], rxd_i};
        end
    end

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            state_q    <= IDLE;
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            rx_ready_o <= 1'b0;
        end else begin
            rx_ready_o <= 1'b0;
            clk_cnt_q  <= clk_cnt_q + 1'b1;
            case (state_q)
                IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rxd_s) state_q <= START;
                end
                START: if (half_end) begin
                    clk_cnt_q <= '0;      // later samples land mid-bit
                    bit_idx_q <= '0;
                    state_q   <= rxd_s ? IDLE : DATA;  // high again means a glitch
                end
                DATA: if (bit_end) begin
                    clk_cnt_q <= '0;
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) state_q <= STOP;
                end
                STOP: if (bit_end) begin
                    state_q    <= IDLE;
                    rx_ready_o <= rxd_s;  // low stop bit drops the byte
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk_i) begin
        if (state_q == DATA && bit_end) begin
            shift_q <= {rxd_s, shift_q[7:1]};
        end
    end

    assign rx_data_o = shift_q;

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  wire                      clk_i,
    input  wire                      locked_i,
    input  wire                      tx_start_i,
    input  wire soc_bus_pkg::byte_t  tx_data_i,
    output logic                     txd_o,
    output logic                     tx_busy_o
);
    import soc_bus_pkg::*;

    uart_state_t state_q;
    baud_cnt_t   clk_cnt_q;
    logic [2:0]  bit_idx_q;
    byte_t       data_q;
    logic        txd_q;
    logic        bit_end;

    assign bit_end   = clk_cnt_q == BIT_LAST;
    assign txd_o     = txd_q;
    assign tx_busy_o = state_q != IDLE;

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && tx_start_i) data_q <= tx_data_i;
    end

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            state_q   <= IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            txd_q     <= 1'b1;  // idle line
        end else begin
            clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
            case (state_q)
                IDLE: begin
                    clk_cnt_q <= '0;
                    bit_idx_q <= '0;
                    if (tx_start_i) begin
                        state_q <= START;
                        txd_q   <= 1'b0;  // start bit
                    end
                end
                START: if (bit_end) begin
                    state_q <= DATA;
                    txd_q   <= data_q[0];
                end
                DATA: if (bit_end) begin
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) begin
                        state_q <= STOP;
                        txd_q   <= 1'b1;
                    end else begin
                        txd_q <= data_q[bit_idx_q + 3'd1];
                    end
                end
                STOP: if (bit_end) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_port.sv
`timescale 1ns/1ns
`default_nettype none

module uart_port (
    input  wire                      clk_i,
    input  wire                      locked_i,
    input  wire                      rxd_i,
    output logic                     txd_o,
    input  wire                      uart_we_i,
    input  wire                      uart_re_i,
    input  wire soc_bus_pkg::byte_t  uart_tx_data_i,
    output logic                     uart_tx_ready_o,
    output logic                     uart_rx_avail_o,
    output soc_bus_pkg::byte_t       uart_rx_data_o
);
    import soc_bus_pkg::*;

    byte_t rx_data;
    logic  rx_ready;     // one-cycle pulse per good byte
    logic  tx_busy;
    byte_t rx_buf_q;
    logic  rx_avail_q;

    uart_rx uart_rx_inst (
        .clk_i      (clk_i),
        .locked_i   (locked_i),
        .rxd_i      (rxd_i),
        .rx_data_o  (rx_data),
        .rx_ready_o (rx_ready)
    );

    // bridge only strobes we while the transmitter is idle
    uart_tx uart_tx_inst (
        .clk_i      (clk_i),
        .locked_i   (locked_i),
        .tx_start_i (uart_we_i),
        .tx_data_i  (uart_tx_data_i),
        .txd_o      (txd_o),
        .tx_busy_o  (tx_busy)
    );

    always_ff @(posedge clk_i) begin
        if (rx_ready) rx_buf_q <= rx_data;
    end

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            rx_avail_q <= 1'b0;
        end else if (rx_ready) begin
            rx_avail_q <= 1'b1;   // new byte beats a read in the same cycle
        end else if (uart_re_i) begin
            rx_avail_q <= 1'b0;
        end
    end

    assign uart_tx_ready_o = ~tx_busy;
    assign uart_rx_avail_o = rx_avail_q;
    assign uart_rx_data_o  = rx_buf_q;

endmodule

`default_nettype wire

// File: rtl/bus_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module bus_bridge (
    // fetch port
    input  wire soc_bus_pkg::addr_t      ifu_addr_i,
    output soc_bus_pkg::word_t           ifu_rdata_o,
    output logic                         ifu_resp_o,
    // load/store port
    input  wire soc_bus_pkg::addr_t      lsu_addr_i,
    input  wire soc_bus_pkg::word_t      lsu_wdata_i,
    input  wire soc_bus_pkg::be_n_t      lsu_be_n_i,
    input  wire                          lsu_re_i,
    input  wire                          lsu_we_i,
    output soc_bus_pkg::word_t           lsu_rdata_o,
    output logic                         lsu_resp_o,
    // base ram
    output soc_bus_pkg::sram_addr_t      base_ram_addr_o,
    output soc_bus_pkg::word_t           base_ram_wdata_o,
    output soc_bus_pkg::be_n_t           base_ram_be_n_o,
    output logic                         base_ram_ce_n_o,
    output logic                         base_ram_oe_n_o,
    output logic                         base_ram_we_n_o,
    input  wire soc_bus_pkg::word_t      base_ram_rdata_i,
    // ext ram
    output soc_bus_pkg::sram_addr_t      ext_ram_addr_o,
    output soc_bus_pkg::word_t           ext_ram_wdata_o,
    output soc_bus_pkg::be_n_t           ext_ram_be_n_o,
    output logic                         ext_ram_ce_n_o,
    output logic                         ext_ram_oe_n_o,
    output logic                         ext_ram_we_n_o,
    input  wire soc_bus_pkg::word_t      ext_ram_rdata_i,
    // uart side
    input  wire                          uart_tx_ready_i,
    input  wire                          uart_rx_avail_i,
    input  wire soc_bus_pkg::byte_t      uart_rx_data_i,
    output logic                         uart_we_o,
    output logic                         uart_re_o,
    output soc_bus_pkg::byte_t           uart_tx_data_o
);
    import soc_bus_pkg::*;

    logic  lsu_req;
    logic  sel_base;
    logic  sel_ext;
    logic  sel_udata;
    logic  sel_ustat;
    logic  lsu_on_base;   // lsu owns base ram this cycle
    logic  tx_stall;
    word_t stat_word;

    assign lsu_req   = lsu_re_i | lsu_we_i;
    assign sel_base  = (lsu_addr_i & RAM_REGION_MASK) == BASE_RAM_BASE;
    assign sel_ext   = (lsu_addr_i & RAM_REGION_MASK) == EXT_RAM_BASE;
    assign sel_udata = lsu_addr_i == UART_DATA_ADDR;
    assign sel_ustat = lsu_addr_i == UART_STAT_ADDR;

    assign lsu_on_base = sel_base & lsu_req;

    // lsu wins base ram over fetch
    assign base_ram_addr_o  = lsu_on_base ? lsu_addr_i[21:2] : ifu_addr_i[21:2];
    assign base_ram_wdata_o = lsu_wdata_i;
    assign base_ram_be_n_o  = lsu_on_base ? lsu_be_n_i : 4'b0000;
    assign base_ram_ce_n_o  = 1'b0;                       // always serving someone
    assign base_ram_oe_n_o  = lsu_on_base & lsu_we_i;
    assign base_ram_we_n_o  = ~(lsu_on_base & lsu_we_i);

    assign ifu_rdata_o = base_ram_rdata_i;
    assign ifu_resp_o  = ~lsu_on_base;  // fetch stalls behind lsu

    // ext ram serves lsu only
    assign ext_ram_addr_o  = lsu_addr_i[21:2];
    assign ext_ram_wdata_o = lsu_wdata_i;
    assign ext_ram_be_n_o  = lsu_be_n_i;
    assign ext_ram_ce_n_o  = ~(sel_ext & lsu_req);
    assign ext_ram_oe_n_o  = ~(sel_ext & lsu_re_i);
    assign ext_ram_we_n_o  = ~(sel_ext & lsu_we_i);

    always_comb begin
        stat_word = '0;
        stat_word[STAT_TX_READY_BIT] = uart_tx_ready_i;
        stat_word[STAT_RX_AVAIL_BIT] = uart_rx_avail_i;
    end

    always_comb begin
        if (sel_base) begin
            lsu_rdata_o = base_ram_rdata_i;
        end else if (sel_ext) begin
            lsu_rdata_o = ext_ram_rdata_i;
        end else if (sel_udata) begin
            lsu_rdata_o = {24'd0, uart_rx_data_i};
        end else if (sel_ustat) begin
            lsu_rdata_o = stat_word;
        end else begin
            lsu_rdata_o = '0;  // unmapped
        end
    end

    // a data write waits for the transmitter to go idle
    assign tx_stall   = sel_udata & lsu_we_i & ~uart_tx_ready_i;
    assign lsu_resp_o = lsu_req & ~tx_stall;

    assign uart_we_o      = sel_udata & lsu_we_i & uart_tx_ready_i;
    assign uart_re_o      = sel_udata & lsu_re_i;
    assign uart_tx_data_o = lsu_wdata_i[7:0];

endmodule

`default_nettype wire

// File: rtl/soc_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top (
    input  wire                          clk_i,
    input  wire                          locked_i,
    // fetch port
    input  wire soc_bus_pkg::addr_t      ifu_addr_i,
    output wire soc_bus_pkg::word_t      ifu_rdata_o,
    output wire                          ifu_resp_o,
    // load/store port
    input  wire soc_bus_pkg::addr_t      lsu_addr_i,
    input  wire soc_bus_pkg::word_t      lsu_wdata_i,
    input  wire soc_bus_pkg::be_n_t      lsu_be_n_i,
    input  wire                          lsu_re_i,
    input  wire                          lsu_we_i,
    output wire soc_bus_pkg::word_t      lsu_rdata_o,
    output wire                          lsu_resp_o,
    // base ram
    output wire soc_bus_pkg::sram_addr_t base_ram_addr_o,
    output wire soc_bus_pkg::word_t      base_ram_wdata_o,
    output wire soc_bus_pkg::be_n_t      base_ram_be_n_o,
    output wire                          base_ram_ce_n_o,
    output wire                          base_ram_oe_n_o,
    output wire                          base_ram_we_n_o,
    input  wire soc_bus_pkg::word_t      base_ram_rdata_i,
    // ext ram
    output wire soc_bus_pkg::sram_addr_t ext_ram_addr_o,
    output wire soc_bus_pkg::word_t      ext_ram_wdata_o,
    output wire soc_bus_pkg::be_n_t      ext_ram_be_n_o,
    output wire                          ext_ram_ce_n_o,
    output wire                          ext_ram_oe_n_o,
    output wire                          ext_ram_we_n_o,
    input  wire soc_bus_pkg::word_t      ext_ram_rdata_i,
    // serial
    input  wire                          rxd_i,
    output wire                          txd_o
);
    import soc_bus_pkg::*;

    wire        uart_tx_ready;
    wire        uart_rx_avail;
    byte_t      uart_rx_data;
    wire        uart_we;         // data register write completes
    wire        uart_re;         // data register read completes
    byte_t      uart_tx_data;

    bus_bridge bus_bridge_inst (
        .ifu_addr_i       (ifu_addr_i),
        .ifu_rdata_o      (ifu_rdata_o),
        .ifu_resp_o       (ifu_resp_o),
        .lsu_addr_i       (lsu_addr_i),
        .lsu_wdata_i      (lsu_wdata_i),
        .lsu_be_n_i       (lsu_be_n_i),
        .lsu_re_i         (lsu_re_i),
        .lsu_we_i         (lsu_we_i),
        .lsu_rdata_o      (lsu_rdata_o),
        .lsu_resp_o       (lsu_resp_o),
        .base_ram_addr_o  (base_ram_addr_o),
        .base_ram_wdata_o (base_ram_wdata_o),
        .base_ram_be_n_o  (base_ram_be_n_o),
        .base_ram_ce_n_o  (base_ram_ce_n_o),
        .base_ram_oe_n_o  (base_ram_oe_n_o),
        .base_ram_we_n_o  (base_ram_we_n_o),
        .base_ram_rdata_i (base_ram_rdata_i),
        .ext_ram_addr_o   (ext_ram_addr_o),
        .ext_ram_wdata_o  (ext_ram_wdata_o),
        .ext_ram_be_n_o   (ext_ram_be_n_o),
        .ext_ram_ce_n_o   (ext_ram_ce_n_o),
        .ext_ram_oe_n_o   (ext_ram_oe_n_o),
        .ext_ram_we_n_o   (ext_ram_we_n_o),
        .ext_ram_rdata_i  (ext_ram_rdata_i),
        .uart_tx_ready_i  (uart_tx_ready),
        .uart_rx_avail_i  (uart_rx_avail),
        .uart_rx_data_i   (uart_rx_data),
        .uart_we_o        (uart_we),
        .uart_re_o        (uart_re),
        .uart_tx_data_o   (uart_tx_data)
    );

    uart_port uart_port_inst (
        .clk_i           (clk_i),
        .locked_i        (locked_i),
        .rxd_i           (rxd_i),
        .txd_o           (txd_o),
        .uart_we_i       (uart_we),
        .uart_re_i       (uart_re),
        .uart_tx_data_i  (uart_tx_data),
        .uart_tx_ready_o (uart_tx_ready),
        .uart_rx_avail_o (uart_rx_avail),
        .uart_rx_data_o  (uart_rx_data)
    );

endmodule

`default_nettype wire

// File: verification/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sram_model (
    input  wire                          clk_i,
    input  wire soc_bus_pkg::sram_addr_t addr_i,
    input  wire soc_bus_pkg::word_t      wdata_i,
    input  wire soc_bus_pkg::be_n_t      be_n_i,
    input  wire                          ce_n_i,
    input  wire                          oe_n_i,
    input  wire                          we_n_i,
    output soc_bus_pkg::word_t           rdata_o
);
    import soc_bus_pkg::*;

    localparam int DEPTH = 1 << 20;

    word_t mem [DEPTH];

    // every word starts as its own word address xor a fixed tag
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'(i) ^ 32'hA5A5_0000;
        end
    end

    always @(posedge clk_i) begin
        if (!ce_n_i && !we_n_i) begin
            for (int b = 0; b < 4; b++) begin
                if (!be_n_i[b]) mem[addr_i][8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    assign rdata_o = (!ce_n_i && !oe_n_i) ? mem[addr_i] : '0;  // async read

endmodule

`default_nettype wire

// File: verification/tb_soc_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_bus_top;
    import soc_bus_pkg::*;

    localparam int SAMPLE_DELAY = 5;                  // ns after the falling edge
    localparam int RESP_LIMIT   = 12 * CLKS_PER_BIT;  // longer than one frame
    localparam int NUM_ENTRIES  = 11;

    typedef enum logic [2:0] {OP_FETCH, OP_LOAD, OP_STORE, OP_SEND, OP_RECV} op_t;
    typedef struct {
        op_t   op;
        addr_t addr;
        word_t data;
        be_n_t be_n;
        word_t exp_val;
    } entry_t;

    logic       clk_i = 1'b0;
    logic       locked_i;
    addr_t      ifu_addr_i, lsu_addr_i;
    word_t      lsu_wdata_i;
    be_n_t      lsu_be_n_i;
    logic       lsu_re_i, lsu_we_i, rxd_i;
    word_t      ifu_rdata_o, lsu_rdata_o;
    wire        ifu_resp_o, lsu_resp_o, txd_o;
    sram_addr_t base_ram_addr_o, ext_ram_addr_o;
    word_t      base_ram_wdata_o, base_ram_rdata_i, ext_ram_wdata_o, ext_ram_rdata_i;
    be_n_t      base_ram_be_n_o, ext_ram_be_n_o;
    wire        base_ram_ce_n_o, base_ram_oe_n_o, base_ram_we_n_o;
    wire        ext_ram_ce_n_o, ext_ram_oe_n_o, ext_ram_we_n_o;
    integer     seed;
    entry_t     stim [NUM_ENTRIES];

    always #10 clk_i = ~clk_i;

    soc_bus_top soc_bus_top_inst (.*);

    sram_model base_ram_inst (
        .clk_i (clk_i), .addr_i (base_ram_addr_o), .wdata_i (base_ram_wdata_o),
        .be_n_i (base_ram_be_n_o), .ce_n_i (base_ram_ce_n_o), .oe_n_i (base_ram_oe_n_o),
        .we_n_i (base_ram_we_n_o), .rdata_o (base_ram_rdata_i)
    );
    sram_model ext_ram_inst (
        .clk_i (clk_i), .addr_i (ext_ram_addr_o), .wdata_i (ext_ram_wdata_o),
        .be_n_i (ext_ram_be_n_o), .ce_n_i (ext_ram_ce_n_o), .oe_n_i (ext_ram_oe_n_o),
        .we_n_i (ext_ram_we_n_o), .rdata_o (ext_ram_rdata_i)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic word_t preload_word(input addr_t addr);
        return {12'd0, addr[21:2]} ^ 32'hA5A5_0000;
    endfunction

    // enabled bytes come from the new word and the rest stay
    function automatic word_t merge_bytes(input word_t new_w, input word_t old_w,
                                          input be_n_t be_n);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = be_n[b] ? old_w[8*b +: 8] : new_w[8*b +: 8];
        end
        return w;
    endfunction

    // base ram spans 4 MiB from its start address
    function automatic logic in_base(input addr_t addr);
        return addr >= BASE_RAM_BASE && addr < BASE_RAM_BASE + 32'h0040_0000;
    endfunction

    // one load/store request held until lsu_resp_o is seen high
    task automatic bus_access(input logic write, input addr_t addr, input word_t wdata,
                              input be_n_t be_n, output word_t rdata,
                              output logic ifu_resp, output int stall);
        @(negedge clk_i);
        lsu_addr_i  = addr;
        lsu_wdata_i = wdata;
        lsu_be_n_i  = be_n;
        lsu_we_i    = write;
        lsu_re_i    = !write;
        stall       = 0;
        #(SAMPLE_DELAY);
        while (!lsu_resp_o && stall < RESP_LIMIT) begin
            @(negedge clk_i);
            #(SAMPLE_DELAY);
            stall++;
        end
        if (!lsu_resp_o) report_timeout("lsu_resp_o never went high");
        rdata    = lsu_rdata_o;
        ifu_resp = ifu_resp_o;
        @(negedge clk_i);  // request completed at the rising edge
        lsu_we_i = 1'b0;
        lsu_re_i = 1'b0;
    endtask

    task automatic run_fetch(input addr_t addr, input word_t exp_val);
        int waited;
        @(negedge clk_i);
        ifu_addr_i = addr;
        waited     = 0;
        #(SAMPLE_DELAY);
        while (!ifu_resp_o && waited < RESP_LIMIT) begin
            @(negedge clk_i);
            #(SAMPLE_DELAY);
            waited++;
        end
        if (!ifu_resp_o) report_timeout("ifu_resp_o never went high");
        check_value("fetch wait cycles", 32'(waited), 32'd0);
        check_value("ifu_rdata_o", ifu_rdata_o, exp_val);
    endtask

    task automatic drive_serial(input byte_t b);
        @(negedge clk_i);
        rxd_i = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk_i);
        for (int i = 0; i < 8; i++) begin
            rxd_i = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk_i);
        end
        rxd_i = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk_i);
    endtask

    // returns at the middle of the stop bit
    task automatic decode_frame(output byte_t b);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (txd_o && waited < 4 * CLKS_PER_BIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (txd_o) report_timeout("no start bit on txd_o");
        repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
        check_value("txd_o start bit", 32'(txd_o), 32'd0);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            b[i] = txd_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk_i);
        check_value("txd_o stop bit", 32'(txd_o), 32'd1);
    endtask

    // second byte sent back to back sees back-pressure
    task automatic run_send(input word_t data);
        word_t rdata;
        logic  ifu_seen;
        int    stall;
        byte_t got0, got1;
        fork
            begin
                decode_frame(got0);
                decode_frame(got1);
            end
            begin
                bus_access(1'b1, UART_DATA_ADDR, data, 4'b0000, rdata, ifu_seen, stall);
                check_value("first tx write stall", 32'(stall), 32'd0);
                bus_access(1'b0, UART_STAT_ADDR, '0, 4'b0000, rdata, ifu_seen, stall);
                check_value("status tx ready bit", 32'(rdata[STAT_TX_READY_BIT]), 32'd0);
                bus_access(1'b1, UART_DATA_ADDR, data >> 8, 4'b0000, rdata, ifu_seen, stall);
                check_value("second tx write held", 32'(stall > 0), 32'd1);
            end
        join
        check_value("txd_o first byte", 32'(got0), 32'(data[7:0]));
        check_value("txd_o second byte", 32'(got1), 32'(data[15:8]));
    endtask

    task automatic run_recv(input byte_t b);
        word_t rdata;
        logic  ifu_seen;
        int    stall;
        int    polls;
        drive_serial(b);
        polls = 0;
        rdata = '0;
        while (!rdata[STAT_RX_AVAIL_BIT] && polls < 64) begin
            bus_access(1'b0, UART_STAT_ADDR, '0, 4'b0000, rdata, ifu_seen, stall);
            polls++;
        end
        if (!rdata[STAT_RX_AVAIL_BIT]) report_timeout("rx available bit never set");
        bus_access(1'b0, UART_DATA_ADDR, '0, 4'b0000, rdata, ifu_seen, stall);
        check_value("uart rx data", rdata, {24'd0, b});
        bus_access(1'b0, UART_STAT_ADDR, '0, 4'b0000, rdata, ifu_seen, stall);
        check_value("status rx avail bit", 32'(rdata[STAT_RX_AVAIL_BIT]), 32'd0);
    endtask

    task automatic build_stimulus();
        word_t ext_data;
        word_t base_data;
        ext_data  = $random(seed);
        base_data = $random(seed);
        stim[0]  = '{OP_FETCH, 32'h8000_0010, '0, 4'h0, preload_word(32'h8000_0010)};
        stim[1]  = '{OP_FETCH, 32'h8012_3458, '0, 4'h0, preload_word(32'h8012_3458)};
        stim[2]  = '{OP_STORE, 32'h8040_0100, ext_data, 4'b1010, '0};
        stim[3]  = '{OP_LOAD, 32'h8040_0100, '0, 4'h0,
                     merge_bytes(ext_data, preload_word(32'h8040_0100), 4'b1010)};
        stim[4]  = '{OP_LOAD, 32'h8000_0200, '0, 4'h0, preload_word(32'h8000_0200)};
        stim[5]  = '{OP_STORE, 32'h8000_0300, base_data, 4'b0000, '0};
        stim[6]  = '{OP_LOAD, 32'h8000_0300, '0, 4'h0, base_data};
        stim[7]  = '{OP_SEND, UART_DATA_ADDR, $random(seed), 4'h0, '0};
        stim[8]  = '{OP_RECV, UART_DATA_ADDR, $random(seed), 4'h0, '0};
        stim[9]  = '{OP_LOAD, 32'h1000_0000, '0, 4'h0, '0};   // unmapped
        stim[10] = '{OP_FETCH, 32'h8000_0300, '0, 4'h0, base_data};
    endtask

    initial begin
        word_t rdata;
        logic  ifu_seen;
        int    stall;
        seed        = 32'h5d3238a5;
        locked_i    = 1'b0;
        ifu_addr_i  = BASE_RAM_BASE;
        lsu_addr_i  = '0;
        lsu_wdata_i = '0;
        lsu_be_n_i  = 4'hF;
        lsu_re_i    = 1'b0;
        lsu_we_i    = 1'b0;
        rxd_i       = 1'b1;
        build_stimulus();
        repeat (5) @(negedge clk_i);
        locked_i = 1'b1;
        #(SAMPLE_DELAY);
        check_value("txd_o after reset", 32'(txd_o), 32'd1);
        check_value("ext_ram_ce_n_o idle", 32'(ext_ram_ce_n_o), 32'd1);
        check_value("ext_ram_oe_n_o idle", 32'(ext_ram_oe_n_o), 32'd1);
        check_value("ext_ram_we_n_o idle", 32'(ext_ram_we_n_o), 32'd1);
        check_value("base_ram_ce_n_o idle", 32'(base_ram_ce_n_o), 32'd0);
        check_value("base_ram_oe_n_o idle", 32'(base_ram_oe_n_o), 32'd0);
        check_value("base_ram_we_n_o idle", 32'(base_ram_we_n_o), 32'd1);
        // transmitter idle and no byte waiting
        bus_access(1'b0, UART_STAT_ADDR, '0, 4'b0000, rdata, ifu_seen, stall);
        check_value("status after reset", rdata, 32'd1 << STAT_TX_READY_BIT);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            case (stim[i].op)
                OP_FETCH: run_fetch(stim[i].addr, stim[i].exp_val);
                OP_SEND:  run_send(stim[i].data);
                OP_RECV:  run_recv(stim[i].data[7:0]);
                default: begin
                    bus_access(stim[i].op == OP_STORE, stim[i].addr, stim[i].data,
                               stim[i].be_n, rdata, ifu_seen, stall);
                    check_value("lsu wait cycles", 32'(stall), 32'd0);
                    check_value("ifu_resp_o", 32'(ifu_seen), 32'(!in_base(stim[i].addr)));
                    if (stim[i].op == OP_LOAD) check_value("lsu_rdata_o", rdata, stim[i].exp_val);
                end
            endcase
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/soc_bus_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_port.sv
rtl/bus_bridge.sv
rtl/soc_bus_top.sv
verification/sram_model.sv
verification/tb_soc_bus_top.sv

// File: Makefile
# Verilator build and run for the SoC bus testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)
